// ==== design/block_accum.sv ====
`timescale 1ns/1ps

module block_accum import cmprs_cfg_pkg::*, cmprs_data_pkg::*; (
    input  logic                   xclk,
    input  logic                   rst,
    input  logic                   ywe,
    input  y_addr_t                y_addr,
    input  sample_t                y_sample,
    input  logic                   cwe,
    input  c_addr_t                c_addr,
    input  sample_t                c_sample,
    input  logic                   wr_page,     // page the strobed sample goes to
    input  logic                   wr_subtract, // subtract_dc of that page
    input  logic                   mb_start,
    input  mb_cfg_t                mb_cfg,      // valid with mb_start
    input  logic [$bits(tile_t):0] avg_ra,      // {page, tile}
    output logic                   avg_ready,   // one pulse per macroblock
    output sample_t                avg_rd       // one cycle after avg_ra
);

    sample_t                  y_smp;     // registered samples, in step with acc_en
    sample_t                  c_smp;
    logic [BLOCKS_COLOR-1:0]  acc_en;    // one-hot block of the registered sample
    logic [BLOCKS_COLOR-1:0]  acc_first; // next sample of the block restarts the sum
    logic [BLOCKS_COLOR-1:0]  last_smp;  // this sample is the 64th
    logic [BLOCKS_COLOR-1:0]  done_p;    // sum complete, average written this cycle
    logic [1:0]               page_d;    // wr_page at acc_en, then at done_p
    logic [1:0]               sub_d;     // wr_subtract, same alignment
    logic signed [SUM_W-1:0]  acc [BLOCKS_COLOR];
    logic [BLOCK_LOG2-1:0]    cnt [BLOCKS_COLOR];
    logic [BLOCKS_COLOR-1:0]  blk_done [2]; // per page
    logic [1:0]               four_pg;      // page holds a jp4 macroblock
    logic [BLOCKS_COLOR-1:0]  need;         // blocks the done page must complete
    logic [BLOCKS_COLOR-1:0]  done_all;
    sample_t                  avg_mem [2][BLOCKS_COLOR];

    always_ff @(posedge xclk) begin
        if (ywe) begin
            y_smp <= y_sample;
        end
        if (cwe) begin
            c_smp <= c_sample;
        end
        page_d <= {page_d[0], wr_page};
        sub_d  <= {sub_d[0], wr_subtract};
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            acc_en <= '0;
        end else begin
            for (int i = 0; i < BLOCKS_JP4; i++) begin
                acc_en[i] <= ywe && (y_addr[7:6] == 2'(i)); // luma block from addr msbs
            end
            acc_en[4] <= cwe && !c_addr[6]; // cb
            acc_en[5] <= cwe && c_addr[6];  // cr
        end
    end

    always_comb begin
        for (int i = 0; i < BLOCKS_COLOR; i++) begin
            last_smp[i] = acc_en[i] && !acc_first[i] && (cnt[i] == BLOCK_LOG2'(BLOCK_PIX - 1));
        end
    end

    // running sums, restarted by the first sample after mb_start
    always_ff @(posedge xclk) begin
        for (int i = 0; i < BLOCKS_COLOR; i++) begin
            if (acc_en[i]) begin
                acc[i] <= (acc_first[i] ? '0 : acc[i])
                          + SUM_W'((i < BLOCKS_JP4) ? y_smp : c_smp);
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            acc_first <= '1;
            done_p    <= '0;
            for (int i = 0; i < BLOCKS_COLOR; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            acc_first <= mb_start ? '1 : (acc_first & ~acc_en); // mb_start wins
            done_p    <= last_smp;
            for (int i = 0; i < BLOCKS_COLOR; i++) begin
                if (acc_en[i]) begin
                    cnt[i] <= acc_first[i] ? BLOCK_LOG2'(1) : cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        need     = four_pg[page_d[1]] ? BLOCKS_COLOR'(2**BLOCKS_JP4 - 1) : '1;
        done_all = blk_done[page_d[1]] | done_p;
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            blk_done[0] <= '0;
            blk_done[1] <= '0;
            four_pg     <= '0;
            avg_ready   <= 1'b0;
        end else begin
            if (|done_p) begin
                blk_done[page_d[1]] <= done_all;
            end
            if (mb_start) begin // new macroblock goes to the other page
                blk_done[~wr_page] <= '0;
                four_pg[~wr_page]  <= (mb_cfg.mode == mode_jp4);
            end
            avg_ready <= |(done_p & need) && ((done_all & need) == need); // last needed block
        end
    end

    // truncated average, 3 cycles after the 64th strobe
    always_ff @(posedge xclk) begin
        for (int i = 0; i < BLOCKS_COLOR; i++) begin
            if (done_p[i]) begin
                avg_mem[page_d[1]][i] <= sub_d[1] ? sample_t'(acc[i] >>> BLOCK_LOG2) : '0;
            end
        end
        avg_rd <= avg_mem[avg_ra[$bits(tile_t)]][avg_ra[$bits(tile_t)-1:0]];
    end

endmodule

// ==== design/cmprs_buf_average.sv ====
`timescale 1ns/1ps

module cmprs_buf_average import cmprs_cfg_pkg::*, cmprs_data_pkg::*; (
    input  logic     xclk,
    input  logic     rst,
    input  logic     ywe,      // luma sample strobe
    input  y_addr_t  y_addr,
    input  sample_t  y_sample,
    input  logic     cwe,      // chroma sample strobe
    input  c_addr_t  c_addr,
    input  sample_t  c_sample,
    input  logic     mb_start, // one per macroblock, before its first sample
    input  mb_cfg_t  mb_cfg,   // valid with mb_start
    output pix_out_t pix_out
);

    logic                                wr_page;
    logic                                rd_page;
    logic [$bits(tile_t)+BLOCK_LOG2-1:0] rd_addr;     // {tile, pixel}
    logic                                rd_en;       // whole readout, chroma buffer
    logic                                y_sel;       // luma tiles only
    logic                                wr_subtract;
    logic                                avg_ready;
    logic [$bits(tile_t):0]              avg_ra;
    sample_t                             avg_rd;
    sample_t                             y_data;
    sample_t                             c_data;
    rd_mark_t                            mark;

    mb_read_ctrl i_mb_read_ctrl (
        .xclk        (xclk),
        .rst         (rst),
        .mb_start    (mb_start),
        .mb_cfg      (mb_cfg),
        .avg_ready   (avg_ready),
        .wr_page     (wr_page),
        .rd_page     (rd_page),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .y_sel       (y_sel),
        .wr_subtract (wr_subtract),
        .avg_ra      (avg_ra),
        .mark        (mark)
    );

    yc_page_buf #(
        .ADDR_W ($bits(y_addr_t))
    ) i_y_buf (
        .xclk    (xclk),
        .we      (ywe),
        .wr_page (wr_page),
        .wr_addr (y_addr),
        .wr_data (y_sample),
        .rd_en   (y_sel),
        .rd_page (rd_page),
        .rd_addr (rd_addr[$bits(y_addr_t)-1:0]), // tile[1:0] selects the luma block
        .rd_data (y_data)
    );

    yc_page_buf #(
        .ADDR_W ($bits(c_addr_t))
    ) i_c_buf (
        .xclk    (xclk),
        .we      (cwe),
        .wr_page (wr_page),
        .wr_addr (c_addr),
        .wr_data (c_sample),
        .rd_en   (rd_en),
        .rd_page (rd_page),
        .rd_addr (rd_addr[$bits(c_addr_t)-1:0]), // tile[0] picks cb or cr
        .rd_data (c_data)
    );

    block_accum i_block_accum (
        .xclk        (xclk),
        .rst         (rst),
        .ywe         (ywe),
        .y_addr      (y_addr),
        .y_sample    (y_sample),
        .cwe         (cwe),
        .c_addr      (c_addr),
        .c_sample    (c_sample),
        .wr_page     (wr_page),
        .wr_subtract (wr_subtract),
        .mb_start    (mb_start),
        .mb_cfg      (mb_cfg),
        .avg_ra      (avg_ra),
        .avg_ready   (avg_ready),
        .avg_rd      (avg_rd)
    );

    dc_subtract i_dc_subtract (
        .xclk    (xclk),
        .rst     (rst),
        .y_data  (y_data),
        .c_data  (c_data),
        .avg_rd  (avg_rd),
        .mark    (mark),
        .pix_out (pix_out)
    );

endmodule

// ==== design/cmprs_cfg_pkg.sv ====
package cmprs_cfg_pkg;

    localparam int BLOCKS_COLOR = 6; // y0..y3, cb, cr; mono keeps the chroma slots
    localparam int BLOCKS_JP4   = 4; // jp4 macroblock is four raw tiles

    // compressor modes, decoded once per macroblock
    typedef enum logic [1:0] {
        mode_color = 2'd0, // 4:2:0 ycbcr
        mode_mono  = 2'd1, // luma only, chroma goes out as zero
        mode_jp4   = 2'd2  // four tiles, no chroma
    } cmprs_mode_t;

    typedef struct packed {
        cmprs_mode_t mode;        // how the macroblock is read back
        logic        subtract_dc; // store block averages, zeros otherwise
        logic        first_mb;    // first macroblock of the frame
        logic        last_mb;     // last macroblock of the frame
    } mb_cfg_t;

endpackage

// ==== design/cmprs_data_pkg.sv ====
package cmprs_data_pkg;

    localparam int SAMPLE_W   = 9;  // signed color converter output
    localparam int OUT_W      = 10; // sample minus average needs one more bit
    localparam int BLOCK_PIX  = 64; // 8x8
    localparam int BLOCK_LOG2 = 6;  // divide by 64
    localparam int SUM_W      = 15; // 64 x 9 bit signed samples

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef logic [7:0] y_addr_t; // [7:6] luma block, [5:0] pixel
    typedef logic [6:0] c_addr_t; // [6] cr/cb, [5:0] pixel
    typedef logic [2:0] tile_t;   // 0..3 luma, 4 cb, 5 cr

    typedef struct packed {
        logic signed [OUT_W-1:0] data; // sample with dc removed
        sample_t                 avr;  // average that was subtracted
        logic                    dv;   // 64 cycles per block
        logic                    ds;   // first pixel of a block
        tile_t                   tn;
        logic                    first;
        logic                    last;
    } pix_out_t;

    // marks produced by the read controller, one cycle after the address
    typedef struct packed {
        logic  dv;
        logic  ds;
        tile_t tn;
        logic  first;
        logic  last;
        logic  chroma_zero; // mono mode, blank tiles 4 and 5
        logic  subtract;    // subtract_dc of the macroblock being read
    } rd_mark_t;

endpackage

// ==== design/dc_subtract.sv ====
`timescale 1ns/1ps

module dc_subtract import cmprs_data_pkg::*; (
    input  logic     xclk,
    input  logic     rst,
    input  sample_t  y_data,  // luma buffer output
    input  sample_t  c_data,  // chroma buffer output
    input  sample_t  avg_rd,  // block average, same cycle as the data
    input  rd_mark_t mark,
    output pix_out_t pix_out  // 3 cycles after the read address
);

    sample_t                 smp_q;  // selected sample
    sample_t                 avg_q;  // average, zero when subtraction is off
    rd_mark_t                mark_q;
    logic signed [OUT_W-1:0] diff;

    always_ff @(posedge xclk) begin
        smp_q <= mark.tn[2] ? c_data : y_data; // tiles 4,5 come from chroma
        avg_q <= mark.subtract ? avg_rd : '0;
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            mark_q <= '0;
        end else begin
            mark_q <= mark;
        end
    end

    always_comb begin
        diff = OUT_W'(smp_q) - OUT_W'(avg_q); // both sign extended
        if (mark_q.chroma_zero && mark_q.tn[2]) begin
            diff = '0; // mono, no random colors
        end
    end

    always_ff @(posedge xclk) begin
        pix_out.data <= diff;
        pix_out.avr  <= avg_q;
        pix_out.tn   <= mark_q.tn;
        if (rst) begin
            pix_out.dv    <= 1'b0;
            pix_out.ds    <= 1'b0;
            pix_out.first <= 1'b0;
            pix_out.last  <= 1'b0;
        end else begin
            pix_out.dv    <= mark_q.dv;
            pix_out.ds    <= mark_q.ds;
            pix_out.first <= mark_q.first;
            pix_out.last  <= mark_q.last;
        end
    end

endmodule

// ==== design/mb_read_ctrl.sv ====
`timescale 1ns/1ps

module mb_read_ctrl import cmprs_cfg_pkg::*, cmprs_data_pkg::*; (
    input  logic                                 xclk,
    input  logic                                 rst,
    input  logic                                 mb_start,
    input  mb_cfg_t                              mb_cfg,
    input  logic                                 avg_ready,   // averages of next page stored
    output logic                                 wr_page,
    output logic                                 rd_page,
    output logic [$bits(tile_t)+BLOCK_LOG2-1:0]  rd_addr,     // {tile, pixel}
    output logic                                 rd_en,       // readout in progress
    output logic                                 y_sel,       // reading a luma tile
    output logic                                 wr_subtract,
    output logic [$bits(tile_t):0]               avg_ra,      // {page, tile}
    output rd_mark_t                             mark         // aligned with buffer data
);

    typedef enum logic {
        st_idle,
        st_read
    } rd_state_t;

    rd_state_t             state;
    mb_cfg_t               cfg_pg [2]; // settings of the macroblock held in each page
    mb_cfg_t               rd_cfg;
    logic [1:0]            pending;    // page written, readout not finished
    logic [1:0]            ready;      // page averages stored
    logic                  fill_page;  // page whose averages complete next
    logic                  rd_next;    // page to read next, pages alternate
    tile_t                 tile;
    logic [BLOCK_LOG2-1:0] pix;
    tile_t                 last_tile;
    logic                  blk_end;
    logic                  start;

    assign rd_cfg      = cfg_pg[rd_page];
    assign last_tile   = (rd_cfg.mode == mode_jp4) ? tile_t'(BLOCKS_JP4 - 1)
                                                   : tile_t'(BLOCKS_COLOR - 1);
    assign blk_end     = (pix == BLOCK_LOG2'(BLOCK_PIX - 1));
    assign start       = (state == st_idle) && ready[rd_next] && pending[rd_next];
    assign rd_en       = (state == st_read);
    assign y_sel       = rd_en && !tile[2]; // tiles 0..3
    assign rd_addr     = {tile, pix};
    assign avg_ra      = {rd_page, tile};
    assign wr_subtract = cfg_pg[wr_page].subtract_dc;

    always_ff @(posedge xclk) begin
        if (rst) begin
            state     <= st_idle;
            wr_page   <= 1'b1; // first mb_start flips to page 0
            rd_page   <= 1'b0;
            rd_next   <= 1'b0;
            fill_page <= 1'b0;
            pending   <= '0;
            ready     <= '0;
            tile      <= '0;
            pix       <= '0;
            cfg_pg[0] <= '0;
            cfg_pg[1] <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state          <= st_read;
                        rd_page        <= rd_next;
                        rd_next        <= ~rd_next;
                        ready[rd_next] <= 1'b0;
                        tile           <= '0;
                        pix            <= '0;
                    end
                end
                st_read: begin
                    pix <= pix + 1'b1;
                    if (blk_end) begin
                        if (tile == last_tile) begin
                            state            <= st_idle;
                            pending[rd_page] <= 1'b0; // page free for the writer
                        end else begin
                            tile <= tile + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
            // writer side after the case, a page may be refilled on its last read cycle
            if (mb_start) begin
                wr_page           <= ~wr_page;
                pending[~wr_page] <= 1'b1;
                cfg_pg[~wr_page]  <= mb_cfg;
            end
            if (avg_ready) begin // macroblocks complete in write order
                ready[fill_page] <= 1'b1;
                fill_page        <= ~fill_page;
            end
        end
    end

    // marks delayed one cycle to match the registered buffer read
    always_ff @(posedge xclk) begin
        if (rst) begin
            mark <= '0;
        end else begin
            mark.dv          <= rd_en;
            mark.ds          <= rd_en && (pix == '0);
            mark.tn          <= tile;
            mark.first       <= rd_en && rd_cfg.first_mb;
            mark.last        <= rd_en && rd_cfg.last_mb;
            mark.chroma_zero <= (rd_cfg.mode == mode_mono);
            mark.subtract    <= rd_cfg.subtract_dc;
        end
    end

endmodule

// ==== design/yc_page_buf.sv ====
`timescale 1ns/1ps

module yc_page_buf import cmprs_data_pkg::*; #(
    parameter int ADDR_W = 8 // address bits within one page
) (
    input  logic              xclk,
    input  logic              we,      // one strobe per sample
    input  logic              wr_page,
    input  logic [ADDR_W-1:0] wr_addr,
    input  sample_t           wr_data,
    input  logic              rd_en,
    input  logic              rd_page,
    input  logic [ADDR_W-1:0] rd_addr,
    output sample_t           rd_data  // one cycle after rd_addr
);

    sample_t mem [2**(ADDR_W+1)]; // page bit is the address msb

    always_ff @(posedge xclk) begin
        if (we) begin
            mem[{wr_page, wr_addr}] <= wr_data;
        end
    end

    // simple dual port, read side registered
    always_ff @(posedge xclk) begin
        if (rd_en) begin
            rd_data <= mem[{rd_page, rd_addr}];
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it from the project root
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top \
    -Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb.f ====
design/cmprs_cfg_pkg.sv
design/cmprs_data_pkg.sv
design/yc_page_buf.sv
design/block_accum.sv
design/mb_read_ctrl.sv
design/dc_subtract.sv
design/cmprs_buf_average.sv
verification/tb_clk_gen.sv
verification/tb_sva.sv
verification/tb_top.sv

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 4.0, // xclk period
    parameter int  RST_CYCLES = 16   // reset length in clock cycles
) (
    output logic xclk,
    output logic rst
);

    initial begin
        xclk = 1'b0;
        forever #(PERIOD_NS / 2.0) xclk = ~xclk;
    end

    // released on a rising edge, the DUT still sees it high on that edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge xclk);
        rst <= 1'b0;
    end

endmodule

// ==== verification/tb_sva.sv ====
`timescale 1ns/1ps

module tb_sva import cmprs_data_pkg::*; (
    input logic     xclk,
    input logic     rst,
    input logic     mb_start,
    input logic     avg_ready,
    input logic     wr_page,
    input logic     rd_page,
    input logic     rd_en,
    input logic     [1:0] pending,  // pages written and not yet read out
    input tile_t    tile,
    input tile_t    last_tile,
    input logic     blk_end,
    input rd_mark_t mark
);

    int unsigned fail_cnt = 0; // assertion failures so far
    logic        seen_ready;   // some page had its averages stored
    logic        rd_last;      // last address of the current readout

    assign rd_last = rd_en && blk_end && (tile == last_tile);

    always_ff @(posedge xclk) begin
        if (rst) begin
            seen_ready <= 1'b0;
        end else if (avg_ready) begin
            seen_ready <= 1'b1;
        end
    end

    // nothing comes out before a complete page
    a_no_early_dv: assert property (@(posedge xclk) disable iff (rst)
        mark.dv |-> seen_ready) else begin
        $error("output valid before any macroblock was complete");
        fail_cnt++;
    end

    // a block start lies inside the readout and opens a new tile
    a_ds_in_dv: assert property (@(posedge xclk) disable iff (rst)
        mark.ds |-> mark.dv && !($past(mark.dv) && (mark.tn == $past(mark.tn)))) else begin
        $error("block start mark without data valid or inside a tile");
        fail_cnt++;
    end

    // the page to be filled must be free or on its last read cycle
    a_third_start: assert property (@(posedge xclk) disable iff (rst)
        mb_start |-> !pending[~wr_page] || (rd_last && (rd_page != wr_page))) else begin
        $error("macroblock start while both pages were still waiting for readout");
        fail_cnt++;
    end

endmodule

bind mb_read_ctrl tb_sva tb_sva_bind (
    .xclk      (xclk),
    .rst       (rst),
    .mb_start  (mb_start),
    .avg_ready (avg_ready),
    .wr_page   (wr_page),
    .rd_page   (rd_page),
    .rd_en     (rd_en),
    .pending   (pending),
    .tile      (tile),
    .last_tile (last_tile),
    .blk_end   (blk_end),
    .mark      (mark)
);

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import cmprs_cfg_pkg::*, cmprs_data_pkg::*; ();

    localparam int N_MB        = 6;   // macroblocks in this run
    localparam int MB_LIMIT    = 10;
    localparam int MB_CYCLES   = 800; // write plus readout of one macroblock with margin
    localparam int CYCLE_LIMIT = MB_LIMIT * MB_CYCLES;

    logic     xclk;
    logic     rst;
    logic     ywe;
    y_addr_t  y_addr;
    sample_t  y_sample;
    logic     cwe;
    c_addr_t  c_addr;
    sample_t  c_sample;
    logic     mb_start;
    mb_cfg_t  mb_cfg;
    pix_out_t pix_out;

    sample_t     ref_y [N_MB][256]; // samples as written for each macroblock
    sample_t     ref_c [N_MB][128]; // cb 0..63, cr 64..127
    mb_cfg_t     ref_cfg [N_MB];
    string       test_name [N_MB];
    int          err_cnt;
    int          mb_written;        // macroblocks whose samples are all in
    int          mb_done;           // macroblocks fully seen on pix_out
    int          out_tn;            // expected tile of the next valid pixel
    int          out_pix;
    int unsigned cycle_cnt;

    tb_clk_gen #(
        .PERIOD_NS  (4.0),
        .RST_CYCLES (16)
    ) i_clk_gen (
        .xclk (xclk),
        .rst  (rst)
    );

    cmprs_buf_average UUT (
        .xclk     (xclk),
        .rst      (rst),
        .ywe      (ywe),
        .y_addr   (y_addr),
        .y_sample (y_sample),
        .cwe      (cwe),
        .c_addr   (c_addr),
        .c_sample (c_sample),
        .mb_start (mb_start),
        .mb_cfg   (mb_cfg),
        .pix_out  (pix_out)
    );

    task automatic check_val(input string name, input int exp_v, input int act_v);
        assert (act_v == exp_v) else begin
            err_cnt++;
            $display("ERR %s: expected %0d, actual %0d", name, exp_v, act_v);
        end
    endtask

    // sum of the 64 samples shifted right arithmetically by 6
    function automatic int block_avg(input int mb, input int tn);
        int s;
        s = 0;
        for (int p = 0; p < BLOCK_PIX; p++) begin
            s += (tn < 4) ? ref_y[mb][tn * BLOCK_PIX + p] : ref_c[mb][(tn - 4) * BLOCK_PIX + p];
        end
        return s >>> BLOCK_LOG2;
    endfunction

    task automatic write_mb(input int mb);
        int yi;
        int ci;
        int c_len;
        yi    = 0;
        ci    = 0;
        c_len = (ref_cfg[mb].mode == mode_jp4) ? 0 : 128; // jp4 has no chroma
        for (int p = 0; p < 256; p++) begin
            ref_y[mb][p] = sample_t'($urandom);
        end
        for (int p = 0; p < 128; p++) begin
            ref_c[mb][p] = sample_t'($urandom);
        end
        while (mb_done + 1 < mb) begin // page of mb-2 must be read out first
            @(negedge xclk);
        end
        mb_start = 1'b1;
        mb_cfg   = ref_cfg[mb];
        @(negedge xclk);
        mb_start = 1'b0;
        mb_cfg   = '0;
        while (yi < 256 || ci < c_len) begin
            ywe      = (yi < 256) && ($urandom_range(3) != 0); // random gaps
            y_addr   = y_addr_t'(yi);
            y_sample = ref_y[mb][yi % 256];
            cwe      = (ci < c_len) && ($urandom_range(3) != 0);
            c_addr   = c_addr_t'(ci);
            c_sample = ref_c[mb][ci % 128];
            if (ywe) begin
                yi++;
            end
            if (cwe) begin
                ci++;
            end
            @(negedge xclk);
        end
        ywe        = 1'b0;
        cwe        = 1'b0;
        mb_written = mb + 1;
    endtask

    task automatic check_pixel();
        int    mb;
        int    smp;
        int    avr_e;
        int    data_e;
        string name;
        mb = mb_done;
        if (!pix_out.dv) begin
            check_val("idle ds", 0, pix_out.ds); // block start only on a valid pixel
            assert (out_tn == 0 && out_pix == 0) else begin
                err_cnt++;
                $display("data valid went low inside the readout of macroblock %0d", mb);
                out_tn  = 0;
                out_pix = 0;
            end
        end else begin
            assert (mb < mb_written) else begin
                err_cnt++;
                $display("pixel output while no written macroblock was waiting");
            end
            if (mb < mb_written) begin
                smp    = (out_tn < 4) ? ref_y[mb][out_tn * BLOCK_PIX + out_pix]
                                      : ref_c[mb][(out_tn - 4) * BLOCK_PIX + out_pix];
                avr_e  = ref_cfg[mb].subtract_dc ? block_avg(mb, out_tn) : 0;
                data_e = (ref_cfg[mb].mode == mode_mono && out_tn >= 4) ? 0 : smp - avr_e;
                name   = $sformatf("%s mb%0d tile%0d pix%0d", test_name[mb], mb, out_tn, out_pix);
                check_val({name, " tn"}, out_tn, pix_out.tn);
                check_val({name, " ds"}, out_pix == 0, pix_out.ds);
                check_val({name, " first"}, ref_cfg[mb].first_mb, pix_out.first);
                check_val({name, " last"}, ref_cfg[mb].last_mb, pix_out.last);
                check_val({name, " avr"}, avr_e, $signed(pix_out.avr));
                check_val({name, " data"}, data_e, $signed(pix_out.data));
                out_pix++;
                if (out_pix == BLOCK_PIX) begin
                    out_pix = 0;
                    out_tn++;
                    if (out_tn == ((ref_cfg[mb].mode == mode_jp4) ? BLOCKS_JP4 : BLOCKS_COLOR)) begin
                        out_tn = 0;
                        mb_done++;
                    end
                end
            end
        end
    endtask

    // outputs only move on the rising edge
    always @(negedge xclk) begin
        if (!rst) begin
            check_pixel();
        end
    end

    always @(posedge xclk) begin
        cycle_cnt++;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout, readout not finished after %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        ywe        = 1'b0;
        y_addr     = '0;
        y_sample   = '0;
        cwe        = 1'b0;
        c_addr     = '0;
        c_sample   = '0;
        mb_start   = 1'b0;
        mb_cfg     = '0;
        err_cnt    = 0;
        mb_written = 0;
        mb_done    = 0;
        out_tn     = 0;
        out_pix    = 0;
        cycle_cnt  = 0;
        void'($urandom(32'hf7d2));
        ref_cfg[0] = '{mode_color, 1'b1, 1'b1, 1'b0}; // first of frame
        ref_cfg[1] = '{mode_color, 1'b0, 1'b0, 1'b0}; // back to back with mb0 on the other page
        ref_cfg[2] = '{mode_jp4, 1'b1, 1'b0, 1'b0};
        ref_cfg[3] = '{mode_mono, 1'b1, 1'b0, 1'b0};  // chroma blanked
        ref_cfg[4] = '{mode_jp4, 1'b0, 1'b0, 1'b0};
        ref_cfg[5] = '{mode_color, 1'b1, 1'b0, 1'b1}; // last of frame
        test_name  = '{"color_sub", "color_nosub", "jp4_sub", "mono_sub", "jp4_nosub",
                       "color_last"};
        while (rst) begin
            @(negedge xclk);
        end
        repeat (20) @(negedge xclk); // idle period with no output allowed
        for (int mb = 0; mb < N_MB; mb++) begin
            write_mb(mb);
        end
        while (mb_done < N_MB) begin
            @(negedge xclk);
        end
        repeat (40) @(negedge xclk); // any extra pixel is flagged by the checker
        $display("check errors: %0d, assertion failures: %0d", err_cnt,
                 UUT.i_mb_read_ctrl.tb_sva_bind.fail_cnt);
        if (err_cnt == 0 && UUT.i_mb_read_ctrl.tb_sva_bind.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
